// File: Makefile
# Verilator build and run for the ray interconnect buffer

VERILATOR ?= verilator
TOP       ?= ray_ic_tb
FILELIST  ?= ray_ic.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result line, see $(LOG)"; exit 1; \
	fi
	@echo "run passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: ray_ic.f
ray_ic_cfg_pkg.sv
ray_ic_types_pkg.sv
ray_queue.sv
ray_ic_buffer.sv
ray_ic_chk.sv
tb_clk_gen.sv
ray_ic_tb.sv

// File: ray_ic_buffer.sv
`timescale 1ns/1ps

module ray_ic_buffer
    import ray_ic_cfg_pkg::*;
    import ray_ic_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // rt2ic, dispatcher
    input  logic                    q_en_rt2ic,
    input  rt_sel_t                 core_sel_rt2ic,

    // rt2ic, traversal cores
    input  vec4_t      [NUM_RT-1:0] ray_origin_rt,
    input  vec4_t      [NUM_RT-1:0] ray_direction_rt,
    input  thread_id_t [NUM_RT-1:0] thread_id_rt_in,

    // rt2ic, intersection side
    input  logic                    dequeue_ic,
    output vec4_t                   ray_origin_ic,
    output vec4_t                   ray_direction_ic,
    output thread_id_t              thread_id_ic_out,
    output logic                    ray_valid_ic,
    output logic                    rt2ic_full,

    // ic2rt, dispatcher
    input  logic                    q_en_ic2rt,
    input  ic_sel_t                 core_sel_ic2rt,

    // ic2rt, intersection cores
    input  vec4_t      [NUM_IC-1:0] shader_info_ic,
    input  vec4_t      [NUM_IC-1:0] normal_ic,
    input  thread_id_t [NUM_IC-1:0] thread_id_ic_in,

    // ic2rt, traversal side
    input  logic                    dequeue_rt,
    output shader_t                 shader_info_rt,
    output vec4_t                   normal_rt,
    output thread_id_t              thread_id_rt_out,
    output logic                    hit_valid_rt,
    output logic                    ic2rt_full
);

    ray_t [NUM_RT-1:0] ray_src;
    hit_t [NUM_IC-1:0] hit_src;
    ray_t              ray_head;
    hit_t              hit_head;

    // pack each traversal core's ray
    always_comb begin
        for (int i = 0; i < NUM_RT; i++) begin
            ray_src[i] = {thread_id_rt_in[i], ray_origin_rt[i], ray_direction_rt[i]};
        end
    end

    // pack each intersection core's hit
    // only the low word of the shader record is forwarded
    always_comb begin
        for (int i = 0; i < NUM_IC; i++) begin
            hit_src[i] = {thread_id_ic_in[i], shader_info_ic[i][SHADER_W-1:0], normal_ic[i]};
        end
    end

    ray_queue #(
        .N_SRC     (NUM_RT),
        .PAYLOAD_W (RAY_W)
    ) u_rt2ic (
        .clk      (clk),
        .rst_n    (rst_n),
        .q_en     (q_en_rt2ic),
        .core_sel (core_sel_rt2ic),
        .src_data (ray_src),
        .dequeue  (dequeue_ic),
        .head     (ray_head),
        .valid    (ray_valid_ic),
        .full     (rt2ic_full)
    );

    ray_queue #(
        .N_SRC     (NUM_IC),
        .PAYLOAD_W (HIT_W)
    ) u_ic2rt (
        .clk      (clk),
        .rst_n    (rst_n),
        .q_en     (q_en_ic2rt),
        .core_sel (core_sel_ic2rt),
        .src_data (hit_src),
        .dequeue  (dequeue_rt),
        .head     (hit_head),
        .valid    (hit_valid_rt),
        .full     (ic2rt_full)
    );

    // unpack queue heads, same field order as the packing above
    assign {thread_id_ic_out, ray_origin_ic, ray_direction_ic} = ray_head;
    assign {thread_id_rt_out, shader_info_rt, normal_rt}       = hit_head;

endmodule

// File: ray_ic_cfg_pkg.sv
package ray_ic_cfg_pkg;

    // core counts on each side of the buffer
    localparam int NUM_RT = 4;
    localparam int NUM_IC = 4;

    // one item in flight per thread, so this is also the queue depth
    localparam int NUM_THREAD = 32;

    // thread id width
    localparam int THREAD_W = $clog2(NUM_THREAD);

    // four packed single floats
    localparam int VEC_W = 128;

    // forwarded part of the shader record
    localparam int SHADER_W = 32;

    // rt2ic payload: thread id, origin, direction
    localparam int RAY_W = THREAD_W + 2 * VEC_W;

    // ic2rt payload: thread id, shader word, normal
    localparam int HIT_W = THREAD_W + SHADER_W + VEC_W;

    // occupancy count, must reach NUM_THREAD itself
    localparam int COUNT_W = $clog2(NUM_THREAD) + 1;

endpackage

// File: ray_ic_chk.sv
`timescale 1ns/1ps

module ray_ic_chk
    import ray_ic_cfg_pkg::*;
    import ray_ic_types_pkg::*;
#(
    parameter int N_SRC = NUM_RT
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             q_en,
    input  logic [N_SRC-1:0] core_sel,
    input  logic             valid,
    input  logic             full,
    input  count_t           count
);

    // read by the testbench top at the end of the run
    int assert_fails = 0;

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= COUNT_W'(NUM_THREAD))
    else begin
        $error("queue count %0d above depth", count);
        assert_fails++;
    end

    a_no_strobe_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(q_en && full))
    else begin
        $error("enqueue strobe while queue is full");
        assert_fails++;
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        q_en |-> $onehot(core_sel))
    else begin
        $error("core select %b not one-hot during strobe", core_sel);
        assert_fails++;
    end

    // empty queue without a strobe stays empty, dequeue pulses included
    a_valid_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (count == '0 && !q_en) |=> !valid)
    else begin
        $error("valid rose on an empty queue without an enqueue");
        assert_fails++;
    end

endmodule

// File: ray_ic_tb.sv
`timescale 1ns/1ps

module ray_ic_tb
    import ray_ic_cfg_pkg::*;
    import ray_ic_types_pkg::*;
();

    localparam int MAX_RECS     = 64;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_MARGIN = 2 * NUM_THREAD + 20;

    logic                    clk;
    logic                    rst_n;
    logic                    q_en_rt2ic;
    rt_sel_t                 core_sel_rt2ic;
    vec4_t      [NUM_RT-1:0] ray_origin_rt;
    vec4_t      [NUM_RT-1:0] ray_direction_rt;
    thread_id_t [NUM_RT-1:0] thread_id_rt_in;
    logic                    dequeue_ic;
    vec4_t                   ray_origin_ic;
    vec4_t                   ray_direction_ic;
    thread_id_t              thread_id_ic_out;
    logic                    ray_valid_ic;
    logic                    rt2ic_full;
    logic                    q_en_ic2rt;
    ic_sel_t                 core_sel_ic2rt;
    vec4_t      [NUM_IC-1:0] shader_info_ic;
    vec4_t      [NUM_IC-1:0] normal_ic;
    thread_id_t [NUM_IC-1:0] thread_id_ic_in;
    logic                    dequeue_rt;
    shader_t                 shader_info_rt;
    vec4_t                   normal_rt;
    thread_id_t              thread_id_rt_out;
    logic                    hit_valid_rt;
    logic                    ic2rt_full;

    logic [31:0] recs [MAX_RECS];
    int          seed = 32'h5194_fb2e;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 100000;

    // model queues, one entry per accepted enqueue
    thread_id_t rq_tid [$];
    vec4_t      rq_org [$];
    vec4_t      rq_dir [$];
    thread_id_t hq_tid [$];
    shader_t    hq_shd [$];
    vec4_t      hq_nrm [$];

    tb_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk (.clk(clk), .rst_n(rst_n));

    ray_ic_buffer dut (.*);

    bind ray_queue ray_ic_chk #(.N_SRC(N_SRC)) u_chk (
        .clk(clk), .rst_n(rst_n), .q_en(q_en), .core_sel(core_sel),
        .valid(valid), .full(full), .count(count)
    );

    task automatic check_value(input string name, input logic [VEC_W-1:0] got,
                               input logic [VEC_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic rand_vec(output vec4_t v);
        v = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // fresh data on every core, selected or not
    task automatic drive_payloads();
        vec4_t v;
        for (int i = 0; i < NUM_RT; i++) begin
            rand_vec(v);
            ray_origin_rt[i] = v;
            rand_vec(v);
            ray_direction_rt[i] = v;
            thread_id_rt_in[i] = thread_id_t'($random(seed));
        end
        for (int i = 0; i < NUM_IC; i++) begin
            rand_vec(v);
            shader_info_ic[i] = v;
            rand_vec(v);
            normal_ic[i] = v;
            thread_id_ic_in[i] = thread_id_t'($random(seed));
        end
    endtask

    task automatic check_outputs();
        int rn;
        int hn;
        rn = rq_tid.size();
        hn = hq_tid.size();
        check_value("ray_valid_ic", ray_valid_ic, rn > 0);
        check_value("rt2ic_full", rt2ic_full, rn == NUM_THREAD);
        check_value("thread_id_ic_out", thread_id_ic_out, (rn > 0) ? rq_tid[0] : '0);
        check_value("ray_origin_ic", ray_origin_ic, (rn > 0) ? rq_org[0] : '0);
        check_value("ray_direction_ic", ray_direction_ic, (rn > 0) ? rq_dir[0] : '0);
        check_value("hit_valid_rt", hit_valid_rt, hn > 0);
        check_value("ic2rt_full", ic2rt_full, hn == NUM_THREAD);
        check_value("thread_id_rt_out", thread_id_rt_out, (hn > 0) ? hq_tid[0] : '0);
        check_value("shader_info_rt", shader_info_rt, (hn > 0) ? hq_shd[0] : '0);
        check_value("normal_rt", normal_rt, (hn > 0) ? hq_nrm[0] : '0);
    endtask

    // drive one cycle and advance the model past the next rising edge
    task automatic drive_cycle(input logic [31:0] rec);
        logic en_r;
        logic en_h;
        int   src_r;
        int   src_h;
        en_r  = rec[28] && (rq_tid.size() < NUM_THREAD);
        en_h  = rec[20] && (hq_tid.size() < NUM_THREAD);
        src_r = int'(rec[27:24]) % NUM_RT;
        src_h = int'(rec[19:16]) % NUM_IC;
        drive_payloads();
        q_en_rt2ic     = en_r;
        core_sel_rt2ic = en_r ? rt_sel_t'(1 << src_r) : '0;
        dequeue_ic     = rec[12];
        q_en_ic2rt     = en_h;
        core_sel_ic2rt = en_h ? ic_sel_t'(1 << src_h) : '0;
        dequeue_rt     = rec[8];
        if (rec[12] && rq_tid.size() > 0) begin
            void'(rq_tid.pop_front());
            void'(rq_org.pop_front());
            void'(rq_dir.pop_front());
        end
        if (en_r) begin
            rq_tid.push_back(thread_id_rt_in[src_r]);
            rq_org.push_back(ray_origin_rt[src_r]);
            rq_dir.push_back(ray_direction_rt[src_r]);
        end
        if (rec[8] && hq_tid.size() > 0) begin
            void'(hq_tid.pop_front());
            void'(hq_shd.pop_front());
            void'(hq_nrm.pop_front());
        end
        if (en_h) begin
            hq_tid.push_back(thread_id_ic_in[src_h]);
            // only the low word of the shader record survives the queue
            hq_shd.push_back(shader_info_ic[src_h][SHADER_W-1:0]);
            hq_nrm.push_back(normal_ic[src_h]);
        end
    endtask

    initial begin
        int total;
        int asserts;
        q_en_rt2ic       = 1'b0;
        core_sel_rt2ic   = '0;
        ray_origin_rt    = '0;
        ray_direction_rt = '0;
        thread_id_rt_in  = '0;
        dequeue_ic       = 1'b0;
        q_en_ic2rt       = 1'b0;
        core_sel_ic2rt   = '0;
        shader_info_ic   = '0;
        normal_ic        = '0;
        thread_id_ic_in  = '0;
        dequeue_rt       = 1'b0;
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '0;
        end
        $readmemh("ray_ic_tests.mem", recs);
        total = 0;
        for (int i = 0; i < MAX_RECS && recs[i][7:0] != 8'h00; i++) begin
            total += int'(recs[i][7:0]);
        end
        cycle_limit = total + RESET_CYCLES + DRAIN_MARGIN;
        if (total == 0) begin
            errors++;
            $display("no test records found in ray_ic_tests.mem");
        end
        @(posedge rst_n);
        for (int i = 0; i < MAX_RECS; i++) begin
            if (recs[i][7:0] == 8'h00) begin
                break;
            end
            for (int r = 0; r < int'(recs[i][7:0]); r++) begin
                @(negedge clk);
                check_outputs();
                drive_cycle(recs[i]);
            end
        end
        @(negedge clk);
        check_outputs();
        asserts = dut.u_rt2ic.u_chk.assert_fails + dut.u_ic2rt.u_chk.assert_fails;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

// File: ray_ic_tests.mem
// one command record per line, one 32-bit hex word, nibbles from the left
// rt2ic enq flag, rt2ic core, ic2rt enq flag, ic2rt core,
// dequeue_ic flag, dequeue_rt flag, then a two-digit repeat count
// a repeat count of 00 ends the list

// idle after reset
00000004
// dequeue pulses on both empty queues
00001103
00000002
// each traversal core in turn
10000001
11000001
12000001
13000001
// each intersection core in turn
00100001
00110001
00120001
00130001
// drain both, then keep pulsing while empty
00001106
// rt2ic traffic only, ic2rt stays idle
12000003
11001004
00001004
// ic2rt traffic only, rt2ic stays idle
00130003
00100104
00000104
// fill rt2ic past full
10000010
11000010
12000004
00000003
00001022
// fill ic2rt past full
00130010
00120010
00110004
00000003
00000122
// push and pop together at several occupancies
11110005
10101108
12120014
13131106
11110008
10101104
12121104
00001124
// mixed traffic, then drain
1213110a
12130004
00001108
00000002
00000000

// File: ray_ic_types_pkg.sv
package ray_ic_types_pkg;

    import ray_ic_cfg_pkg::*;

    // per-thread tag carried with every item
    typedef logic [THREAD_W-1:0] thread_id_t;

    // origin, direction, normal or raw shader record
    typedef logic [VEC_W-1:0] vec4_t;

    // low word of the shader record
    typedef logic [SHADER_W-1:0] shader_t;

    // one-hot core selects from the dispatcher
    typedef logic [NUM_RT-1:0] rt_sel_t;
    typedef logic [NUM_IC-1:0] ic_sel_t;

    // queue payloads
    // ray_t is {thread id, origin, direction}
    typedef logic [RAY_W-1:0] ray_t;

    // hit_t is {thread id, shader word, normal}
    typedef logic [HIT_W-1:0] hit_t;

    // queue occupancy, 0 to NUM_THREAD
    typedef logic [COUNT_W-1:0] count_t;

endpackage

// File: ray_queue.sv
`timescale 1ns/1ps

module ray_queue
    import ray_ic_cfg_pkg::*;
    import ray_ic_types_pkg::*;
#(
    parameter int N_SRC     = NUM_RT,
    parameter int PAYLOAD_W = RAY_W
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // write side, one strobe and a one-hot core select
    input  logic                            q_en,
    input  logic [N_SRC-1:0]                core_sel,
    input  logic [N_SRC-1:0][PAYLOAD_W-1:0] src_data,

    // read side
    input  logic                            dequeue,
    output logic [PAYLOAD_W-1:0]            head,
    output logic                            valid,
    output logic                            full
);

    logic [PAYLOAD_W-1:0] mem [NUM_THREAD];
    logic [PAYLOAD_W-1:0] wr_data;
    count_t               count;
    count_t               wr_idx;
    logic                 accept;
    logic                 pop;

    // qualified handshakes
    // strobe only counts while there is room
    assign accept = q_en & ~full;

    // dequeue pulse on an empty queue is dropped
    assign pop = dequeue & valid;

    // status flags come straight off the count
    assign valid = (count != '0);
    assign full  = (count == COUNT_W'(NUM_THREAD));

    // AND-OR select of the source payload
    always_comb begin
        wr_data = '0;
        for (int i = 0; i < N_SRC; i++) begin
            wr_data = wr_data | (src_data[i] & {PAYLOAD_W{core_sel[i]}});
        end
    end

    // tail slot, one lower when the head leaves in the same cycle
    always_comb begin
        if (pop) begin
            wr_idx = count - 1'b1;
        end else begin
            wr_idx = count;
        end
    end

    // storage
    // a pop shifts every entry toward slot 0, then the write lands at wr_idx
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_THREAD; i++) begin
            if (accept && (wr_idx == COUNT_W'(i))) begin
                mem[i] <= wr_data;
            end else if (pop && (i < NUM_THREAD - 1)) begin
                mem[i] <= mem[i + 1];
            end
        end
    end

    // occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({accept, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // idle, or push and pop together
                    count <= count;
                end
            endcase
        end
    end

    // head reads as zero while the queue is empty
    // keeps stale or unwritten slots off the outputs
    always_comb begin
        if (valid) begin
            head = mem[0];
        end else begin
            head = '0;
        end
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real HALF_PERIOD  = 2.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
